/* src/sc_consts.svh */
`ifndef SC_CONSTS_SVH
`define SC_CONSTS_SVH

// ==============================
// Bridge identification.
// ==============================
`define SC_VERSION 32'h5343_0102

// ==============================
// Command engine.
// ==============================
`define CMD_ADD    8'h41 // 'A'.
`define CMD_XOR    8'h58 // 'X'.
`define CMD_SWAP   8'h53 // 'S'.
`define CMD_CYCLES 4     // Busy cycles for add and xor.

// Scratch buffer size in 16-bit words.
`define BUF_WORDS 8

`endif

/* src/sc_pkg.sv */
`default_nettype none

package sc_pkg;

    // ==============================
    // Console bus.
    // ==============================
    typedef struct packed {
        logic        request;
        logic        write;
        logic [4:0]  address; // Byte address with bit 4 picking the buffer.
        logic [15:0] wdata;
    } n64_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] rdata;   // Zero outside ack.
    } n64_rsp_t;

    // Slave side handshake machine.
    typedef enum logic [0:0] {
        S_IDLE,
        S_WAIT
    } bus_state_e;

    // ==============================
    // Register block and engine.
    // ==============================
    typedef struct packed {
        logic cpu_ready;
        logic cpu_busy;
        logic cmd_error;
    } cfg_status_t;

    typedef struct packed {
        logic [1:0]  data_write; // One bit per data register.
        logic [31:0] wdata;
    } cfg_update_t;

    typedef enum logic [2:0] {
        R_SR,
        R_COMMAND,
        R_DATA_0_H,
        R_DATA_0_L,
        R_DATA_1_H,
        R_DATA_1_L,
        R_VERSION_H,
        R_VERSION_L
    } reg_id_e;

endpackage

`default_nettype wire

/* src/n64_bus_fabric.sv */
`timescale 1ns/100ps
`default_nettype none

module n64_bus_fabric (
    input  sc_pkg::n64_req_t bus_req,
    output sc_pkg::n64_rsp_t bus_rsp,
    output sc_pkg::n64_req_t cfg_req,
    output sc_pkg::n64_req_t buf_req,
    input  sc_pkg::n64_rsp_t cfg_rsp,
    input  sc_pkg::n64_rsp_t buf_rsp
);

    logic sel_buf;

    assign sel_buf = bus_req.address[4];

    // ==============================
    // Request split.
    // ==============================
    always_comb begin
        cfg_req         = bus_req;
        cfg_req.request = bus_req.request & ~sel_buf;

        buf_req         = bus_req;
        buf_req.request = bus_req.request & sel_buf;
    end

    // ==============================
    // Response merge.
    // ==============================
    always_comb begin
        bus_rsp.ack = cfg_rsp.ack | buf_rsp.ack;
        if (buf_rsp.ack) begin
            bus_rsp.rdata = buf_rsp.rdata;
        end else if (cfg_rsp.ack) begin
            bus_rsp.rdata = cfg_rsp.rdata;
        end else begin
            bus_rsp.rdata = 16'd0; // Idle bus reads as zero.
        end
    end

endmodule

`default_nettype wire

/* src/n64_cfg_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sc_consts.svh"

module n64_cfg_regs (
    input  logic               sys,
    input  logic               reset,
    input  sc_pkg::n64_req_t   bus_req,
    output sc_pkg::n64_rsp_t   bus_rsp,
    input  sc_pkg::cfg_status_t status,
    input  sc_pkg::cfg_update_t update,
    output logic [7:0]         cmd,
    output logic               cmd_request,
    output logic [31:0]        data0,
    output logic [31:0]        data1
);

    import sc_pkg::*;

    localparam logic [31:0] VERSION = `SC_VERSION;

    bus_state_e  state;
    reg_id_e     reg_id;
    logic        ack;
    logic [15:0] rdata;

    assign reg_id = reg_id_e'(bus_req.address[3:1]);

    // ==============================
    // Read path.
    // ==============================
    always_comb begin
        rdata = 16'd0;
        if (ack) begin
            case (reg_id)
                R_SR: rdata = {
                    status.cpu_ready,
                    status.cpu_busy,
                    1'b0,
                    status.cmd_error,
                    12'd0
                };
                R_COMMAND:   rdata = {8'd0, cmd};
                R_DATA_0_H:  rdata = data0[31:16];
                R_DATA_0_L:  rdata = data0[15:0];
                R_DATA_1_H:  rdata = data1[31:16];
                R_DATA_1_L:  rdata = data1[15:0];
                R_VERSION_H: rdata = VERSION[31:16];
                R_VERSION_L: rdata = VERSION[15:0];
                default:     rdata = 16'd0;
            endcase
        end
    end

    assign bus_rsp = '{ack: ack, rdata: rdata};

    // ==============================
    // Write path and handshake.
    // ==============================
    always_ff @(posedge sys) begin
        if (reset) begin
            state       <= S_IDLE;
            ack         <= 1'b0;
            cmd_request <= 1'b0;
            cmd         <= 8'd0;
            data0       <= 32'd0;
            data1       <= 32'd0;
        end else begin
            ack         <= 1'b0;
            cmd_request <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (bus_req.request) begin
                        state <= S_WAIT;
                        ack   <= 1'b1;
                        if (bus_req.write) begin
                            case (reg_id)
                                R_COMMAND: begin
                                    cmd         <= bus_req.wdata[7:0];
                                    cmd_request <= 1'b1;
                                end
                                R_DATA_0_H: data0[31:16] <= bus_req.wdata;
                                R_DATA_0_L: data0[15:0]  <= bus_req.wdata;
                                R_DATA_1_H: data1[31:16] <= bus_req.wdata;
                                R_DATA_1_L: data1[15:0]  <= bus_req.wdata;
                                default: ; // Status and version are read only.
                            endcase
                        end
                    end
                end

                S_WAIT: state <= S_IDLE;

                default: state <= S_IDLE;
            endcase

            // Engine results override a bus write in the same cycle.
            if (update.data_write[0]) data0 <= update.wdata;
            if (update.data_write[1]) data1 <= update.wdata;
        end
    end

endmodule

`default_nettype wire

/* src/n64_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sc_consts.svh"

module n64_buffer (
    input  logic             sys,
    input  logic             reset,
    input  sc_pkg::n64_req_t bus_req,
    output sc_pkg::n64_rsp_t bus_rsp
);

    import sc_pkg::*;

    localparam int IDX_W = $clog2(`BUF_WORDS);

    logic [15:0]      mem [`BUF_WORDS];
    logic [IDX_W-1:0] idx;
    bus_state_e       state;
    logic             ack;

    assign idx = bus_req.address[IDX_W:1]; // Word index above the byte lane bit.

    // ==============================
    // Handshake.
    // ==============================
    always_ff @(posedge sys) begin
        if (reset) begin
            state <= S_IDLE;
            ack   <= 1'b0;
        end else begin
            ack <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (bus_req.request) begin
                        state <= S_WAIT;
                        ack   <= 1'b1;
                    end
                end
                S_WAIT:  state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Storage.
    always_ff @(posedge sys) begin
        if (state == S_IDLE && bus_req.request && bus_req.write) begin
            mem[idx] <= bus_req.wdata;
        end
    end

    assign bus_rsp = '{ack: ack, rdata: ack ? mem[idx] : 16'd0};

endmodule

`default_nettype wire

/* src/cfg_cmd_engine.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sc_consts.svh"

module cfg_cmd_engine (
    input  logic                sys,
    input  logic                reset,
    input  logic [7:0]          cmd,
    input  logic                cmd_request,
    input  logic [31:0]         data0,
    input  logic [31:0]         data1,
    output sc_pkg::cfg_status_t status,
    output sc_pkg::cfg_update_t update
);

    import sc_pkg::*;

    localparam int CNT_W = $clog2(`CMD_CYCLES + 1);

    logic             busy;
    logic             error;
    logic [7:0]       op;
    logic [CNT_W-1:0] count;
    logic [31:0]      opa;
    logic [31:0]      opb;
    logic             known;
    logic             accept;
    logic             last;

    assign known  = cmd inside {`CMD_ADD, `CMD_XOR, `CMD_SWAP};
    assign accept = cmd_request & ~busy; // Requests during busy are dropped.
    assign last   = busy && count == '0;

    // ==============================
    // Control.
    // ==============================
    always_ff @(posedge sys) begin
        if (reset) begin
            busy  <= 1'b0;
            error <= 1'b0;
            op    <= 8'd0;
            count <= '0;
        end else if (busy) begin
            if (last) busy <= 1'b0;
            else count <= count - 1'b1;
        end else if (accept) begin
            if (known) begin
                busy  <= 1'b1;
                error <= 1'b0;
                op    <= cmd;
                count <= (cmd == `CMD_SWAP) ? CNT_W'(1) : CNT_W'(`CMD_CYCLES - 1);
            end else begin
                error <= 1'b1;
            end
        end
    end

    // Operand snapshot.
    always_ff @(posedge sys) begin
        if (accept) begin
            opa <= data0;
            opb <= data1;
        end
    end

    // Result write back.
    always_comb begin
        update = '0;
        if (busy && op == `CMD_SWAP) begin
            if (last) begin
                update.data_write = 2'b01;
                update.wdata      = opb;
            end else begin
                update.data_write = 2'b10;
                update.wdata      = opa;
            end
        end else if (last) begin
            update.data_write = 2'b01;
            update.wdata      = (op == `CMD_ADD) ? opa + opb : opa ^ opb;
        end
    end

    assign status = '{cpu_ready: ~busy, cpu_busy: busy, cmd_error: error};

endmodule

`default_nettype wire

/* src/n64_cfg_top.sv */
`timescale 1ns/100ps
`default_nettype none

module n64_cfg_top (
    input  logic             sys,
    input  logic             reset,
    input  sc_pkg::n64_req_t bus_req,
    output sc_pkg::n64_rsp_t bus_rsp
);

    import sc_pkg::*;

    n64_req_t    cfg_req;
    n64_req_t    buf_req;
    n64_rsp_t    cfg_rsp;
    n64_rsp_t    buf_rsp;
    cfg_status_t status;
    cfg_update_t update;
    logic [7:0]  cmd;
    logic        cmd_request;
    logic [31:0] data0;
    logic [31:0] data1;

    n64_bus_fabric i_fabric (
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .cfg_req (cfg_req),
        .buf_req (buf_req),
        .cfg_rsp (cfg_rsp),
        .buf_rsp (buf_rsp)
    );

    n64_cfg_regs i_regs (
        .sys         (sys),
        .reset       (reset),
        .bus_req     (cfg_req),
        .bus_rsp     (cfg_rsp),
        .status      (status),
        .update      (update),
        .cmd         (cmd),
        .cmd_request (cmd_request),
        .data0       (data0),
        .data1       (data1)
    );

    n64_buffer i_buffer (
        .sys     (sys),
        .reset   (reset),
        .bus_req (buf_req),
        .bus_rsp (buf_rsp)
    );

    cfg_cmd_engine i_engine (
        .sys         (sys),
        .reset       (reset),
        .cmd         (cmd),
        .cmd_request (cmd_request),
        .data0       (data0),
        .data1       (data1),
        .status      (status),
        .update      (update)
    );

endmodule

`default_nettype wire

/* test/tb_n64_cfg.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sc_consts.svh"

module tb_n64_cfg;

    import sc_pkg::*;

    localparam int MAX_CYCLES = 2000; // About five times the length of all tests.
    localparam int ACK_LIMIT  = 8;
    localparam logic [31:0] VERSION = `SC_VERSION;

    logic        sys;
    logic        reset;
    n64_req_t    bus_req;
    n64_rsp_t    bus_rsp;

    int          errors;
    int          checks;
    int          tests;
    int          test_errors;
    int          cycles;
    logic [31:0] rng_state;
    logic [31:0] data0_m;
    logic [31:0] data1_m;
    logic [15:0] buf_m [`BUF_WORDS];

    n64_cfg_top i_dut (
        .sys     (sys),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    initial begin
        sys = 1'b0;
        forever #50 sys = ~sys;
    end

    always @(posedge sys) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // ==============================
    // Bus rules.
    // ==============================
    assert property (@(posedge sys) disable iff (reset) bus_req.request |=> bus_rsp.ack)
        else begin
            $display("Bus error: request was not acknowledged on the next cycle");
            errors++;
        end

    assert property (@(posedge sys) disable iff (reset) bus_rsp.ack |-> $past(bus_req.request))
        else begin
            $display("Bus error: acknowledge without a request");
            errors++;
        end

    assert property (@(posedge sys) disable iff (reset) bus_rsp.ack |=> !bus_rsp.ack)
        else begin
            $display("Bus error: acknowledge held for more than one cycle");
            errors++;
        end

    assert property (@(posedge sys) disable iff (reset) !bus_rsp.ack |-> bus_rsp.rdata == 16'd0)
        else begin
            $display("[FAIL] bus_rsp.rdata: got 0x%h outside ack, expected 0x0000",
                     bus_rsp.rdata);
            errors++;
        end

    // ==============================
    // Helpers.
    // ==============================
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [15:0] next_word();
        logic [31:0] r;
        r = next_random();
        return r[23:8];
    endfunction

    function automatic logic [4:0] reg_addr(reg_id_e id);
        return {1'b0, id, 1'b0};
    endfunction

    function automatic logic [4:0] buf_addr(int idx);
        return {1'b1, idx[2:0], 1'b0};
    endfunction

    // Status word with ready in bit 15, busy in 14 and error in 12.
    function automatic logic [15:0] status_word(logic ready, logic busy, logic err);
        return {ready, busy, 1'b0, err, 12'd0};
    endfunction

    task automatic check_value(string name, logic [15:0] got, logic [15:0] exp);
        checks++;
        assert (got === exp)
            else begin
                $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
                errors++;
            end
    endtask

    task automatic bus_op(input logic is_write, input logic [4:0] addr,
                          input logic [15:0] wdata, output logic [15:0] rdata);
        int waited;
        waited = 1;
        @(posedge sys);
        bus_req <= '{request: 1'b1, write: is_write, address: addr, wdata: wdata};
        @(posedge sys);
        bus_req.request <= 1'b0;
        @(negedge sys);
        while (!bus_rsp.ack && waited < ACK_LIMIT) begin
            waited++;
            @(negedge sys);
        end
        if (!bus_rsp.ack) begin
            $display("No acknowledge for address 0x%h within %0d cycles", addr, ACK_LIMIT);
            errors++;
        end else begin
            assert (waited == 1)
                else begin
                    $display("Acknowledge for address 0x%h came %0d cycles late", addr, waited);
                    errors++;
                end
        end
        rdata = bus_rsp.rdata;
    endtask

    task automatic reg_write(reg_id_e id, logic [15:0] value);
        logic [15:0] unused;
        bus_op(1'b1, reg_addr(id), value, unused);
    endtask

    task automatic expect_reg(reg_id_e id, logic [15:0] exp);
        logic [15:0] got;
        bus_op(1'b0, reg_addr(id), 16'd0, got);
        check_value(id.name(), got, exp);
    endtask

    task automatic expect_data();
        expect_reg(R_DATA_0_H, data0_m[31:16]);
        expect_reg(R_DATA_0_L, data0_m[15:0]);
        expect_reg(R_DATA_1_H, data1_m[31:16]);
        expect_reg(R_DATA_1_L, data1_m[15:0]);
    endtask

    task automatic load_operands();
        data0_m = next_random();
        data1_m = next_random();
        reg_write(R_DATA_0_H, data0_m[31:16]);
        reg_write(R_DATA_0_L, data0_m[15:0]);
        reg_write(R_DATA_1_H, data1_m[31:16]);
        reg_write(R_DATA_1_L, data1_m[15:0]);
    endtask

    task automatic wait_idle();
        logic [15:0] sr;
        int          polls;
        polls = 0;
        sr    = 16'hffff;
        while (sr[14] && polls < 20) begin
            bus_op(1'b0, reg_addr(R_SR), 16'd0, sr);
            polls++;
        end
        if (sr[14]) begin
            $display("Command engine stayed busy after %0d status reads", polls);
            errors++;
        end
    endtask

    // Busy must show right after a known command is written.
    task automatic run_cmd(logic [7:0] code);
        reg_write(R_COMMAND, {8'd0, code});
        expect_reg(R_SR, status_word(1'b0, 1'b1, 1'b0));
        wait_idle();
        expect_reg(R_SR, status_word(1'b1, 1'b0, 1'b0));
    endtask

    task automatic finish_test(string name);
        tests++;
        $display("Test %0d %s finished with %0d errors", tests, name, errors - test_errors);
        test_errors = errors;
    endtask

    // ==============================
    // Tests.
    // ==============================
    initial begin
        logic [15:0] got;
        logic [15:0] w;

        errors      = 0;
        checks      = 0;
        tests       = 0;
        test_errors = 0;
        cycles      = 0;
        rng_state   = 32'h4d0a_8e7c;
        reset       = 1'b1;
        bus_req     = '0;
        repeat (4) @(posedge sys);
        reset <= 1'b0;

        data0_m = 32'd0;
        data1_m = 32'd0;
        expect_reg(R_SR, status_word(1'b1, 1'b0, 1'b0));
        expect_data();
        expect_reg(R_VERSION_H, VERSION[31:16]);
        expect_reg(R_VERSION_L, VERSION[15:0]);
        finish_test("reset_and_version");

        load_operands();
        expect_data();
        for (int i = 0; i < `BUF_WORDS; i++) begin
            buf_m[i] = next_word();
            bus_op(1'b1, buf_addr(i), buf_m[i], got);
        end
        for (int i = 0; i < `BUF_WORDS; i++) begin
            bus_op(1'b0, buf_addr(i), 16'd0, got);
            check_value($sformatf("buffer[%0d]", i), got, buf_m[i]);
        end
        reg_write(R_SR, next_word());
        reg_write(R_VERSION_H, next_word());
        reg_write(R_VERSION_L, next_word());
        expect_reg(R_SR, status_word(1'b1, 1'b0, 1'b0));
        expect_reg(R_VERSION_H, VERSION[31:16]);
        expect_reg(R_VERSION_L, VERSION[15:0]);
        finish_test("read_back");

        for (int i = 0; i < 2; i++) begin
            load_operands();
            run_cmd(`CMD_ADD);
            data0_m = data0_m + data1_m; // Wraps at 32 bits.
            expect_data();
            expect_reg(R_COMMAND, {8'd0, `CMD_ADD});
            load_operands();
            run_cmd(`CMD_XOR);
            data0_m = data0_m ^ data1_m;
            expect_data();
        end
        finish_test("add_and_xor");

        load_operands();
        run_cmd(`CMD_SWAP);
        {data0_m, data1_m} = {data1_m, data0_m};
        expect_data();
        finish_test("swap");

        load_operands();
        reg_write(R_COMMAND, 16'h00a5);
        expect_reg(R_SR, status_word(1'b1, 1'b0, 1'b1));
        expect_data();
        run_cmd(`CMD_XOR); // Clears the error on accept.
        data0_m = data0_m ^ data1_m;
        expect_data();
        finish_test("unknown_command");

        // Register and buffer requests issued right after each acknowledge.
        for (int i = 0; i < `BUF_WORDS; i++) begin
            w        = next_word();
            buf_m[i] = w;
            bus_op(1'b1, buf_addr(i), w, got);
            expect_reg(R_DATA_1_L, data1_m[15:0]);
            bus_op(1'b0, buf_addr(i), 16'd0, got);
            check_value($sformatf("buffer[%0d]", i), got, buf_m[i]);
        end
        repeat (3) @(posedge sys);
        @(negedge sys);
        check_value("bus_rsp.ack", {15'd0, bus_rsp.ack}, 16'd0);
        finish_test("bus_handshake");

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
src/sc_pkg.sv
src/n64_bus_fabric.sv
src/n64_cfg_regs.sv
src/n64_buffer.sv
src/cfg_cmd_engine.sv
src/n64_cfg_top.sv
test/tb_n64_cfg.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_n64_cfg
FILELIST  ?= build.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
